//--- all.f
+incdir+.
mem_pkg.sv
mem_bank.sv
bank_arbiter.sv
mem_port_ctrl.sv
mem_main.sv
mem_main_tb.sv

//--- bank_arbiter.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module bank_arbiter import mem_pkg::*; #(
    parameter int NUM_RT = `MEM_NUM_RT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [NUM_RT-1:0]      core_req,
    input  logic                   core_we [NUM_RT],
    input  logic [`MEM_ROW_W-1:0]  core_row [NUM_RT],
    input  logic [`MEM_DATA_W-1:0] core_data [NUM_RT],
    input  logic                   mc_req,
    input  logic [`MEM_ROW_W-1:0]  mc_row,
    input  logic                   clr_busy,
    output logic [NUM_RT-1:0]      core_gnt,
    output logic                   mc_gnt,
    output bank_cmd_t              cmd
);

    localparam int PTR_W = (NUM_RT > 1) ? $clog2(NUM_RT) : 1;

    logic [PTR_W-1:0] rr_ptr;
    logic [PTR_W-1:0] gnt_idx;
    logic [PTR_W-1:0] ptr_nxt;
    logic             found;
    logic             core_win;

    // first requesting core at or after the pointer.
    always_comb begin
        int cand;
        found   = 1'b0;
        gnt_idx = '0;
        cand    = 0;
        for (int i = 0; i < NUM_RT; i++) begin
            cand = (int'(rr_ptr) + i) % NUM_RT;
            if (!found && core_req[cand]) begin
                found   = 1'b1;
                gnt_idx = PTR_W'(cand);
            end
        end
    end

    // memory controller always wins, nothing goes out during the clear sweep.
    assign mc_gnt   = mc_req && !clr_busy;
    assign core_win = found && !mc_req && !clr_busy;

    always_comb begin
        core_gnt = '0;
        if (core_win) begin
            core_gnt[gnt_idx] = 1'b1;
        end
    end

    always_comb begin
        cmd = '0;
        if (mc_gnt) begin
            cmd.en  = 1'b1; // read only.
            cmd.row = mc_row;
        end else if (core_win) begin
            cmd.en   = 1'b1;
            cmd.we   = core_we[gnt_idx];
            cmd.row  = core_row[gnt_idx];
            cmd.data = core_data[gnt_idx];
        end
    end

    // pointer moves one past the granted port.
    assign ptr_nxt = (gnt_idx == PTR_W'(NUM_RT - 1)) ? '0 : gnt_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (core_win) begin
            rr_ptr <= ptr_nxt;
        end
    end

endmodule

//--- mem_bank.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_bank import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  bank_cmd_t              cmd,
    output logic [`MEM_DATA_W-1:0] rd_data,
    output logic                   clr_busy
);

    logic [`MEM_DATA_W-1:0] mem [`MEM_BANK_DEPTH];
    logic [`MEM_ROW_W-1:0]  clr_row;

    // clears one row per cycle after reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clr_busy <= 1'b1;
            clr_row  <= '0;
        end else if (clr_busy) begin
            clr_row <= clr_row + 1'b1;
            if (clr_row == `MEM_ROW_W'(`MEM_BANK_DEPTH - 1)) begin
                clr_busy <= 1'b0; // last row done.
            end
        end
    end

    // the sweep and the arbiter share one write port.
    always_ff @(posedge clk) begin
        if (clr_busy) begin
            mem[clr_row] <= '0;
        end else if (cmd.en && cmd.we) begin
            mem[cmd.row] <= cmd.data;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.en && !cmd.we) begin
            rd_data <= mem[cmd.row]; // registered read.
        end
    end

endmodule

//--- mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// bus widths.
`define MEM_ADDR_W 32
`define MEM_DATA_W 128

// bank geometry.
`define MEM_NUM_BANK 4
`define MEM_BANK_DEPTH 256
`define MEM_BANK_W 2
`define MEM_ROW_W 8

// bit positions of the bank and row fields in a byte address.
`define MEM_BANK_LSB 2
`define MEM_ROW_LSB 4

// default number of ray-tracing core ports.
`define MEM_NUM_RT 4

`endif

//--- mem_main.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_main import mem_pkg::*; #(
    parameter int NUM_RT = `MEM_NUM_RT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_req_t               rt_req [NUM_RT],
    output mem_rsp_t               rt_rsp [NUM_RT],
    input  logic                   re_mc,
    input  logic [`MEM_ADDR_W-1:0] addr_mc,
    output logic [`MEM_DATA_W-1:0] data_mc,
    output logic                   rdy_mc
);

    logic [`MEM_BANK_W-1:0]  port_bank [NUM_RT];
    logic [`MEM_ROW_W-1:0]   port_row [NUM_RT];
    logic                    port_req [NUM_RT];
    logic                    port_we [NUM_RT];
    logic [`MEM_DATA_W-1:0]  port_data [NUM_RT];
    logic [NUM_RT-1:0]       port_gnt;

    logic [NUM_RT-1:0]       bank_core_req [`MEM_NUM_BANK];
    logic [NUM_RT-1:0]       bank_core_gnt [`MEM_NUM_BANK];
    bank_cmd_t               bank_cmd [`MEM_NUM_BANK];
    logic [`MEM_DATA_W-1:0]  bank_rd_data [`MEM_NUM_BANK];
    logic [`MEM_NUM_BANK-1:0] mc_req;
    logic [`MEM_NUM_BANK-1:0] mc_gnt;
    logic [`MEM_NUM_BANK-1:0] clr_busy;

    logic [`MEM_BANK_W-1:0]  mc_bank;
    logic [`MEM_BANK_W-1:0]  mc_bank_q;
    logic [`MEM_ROW_W-1:0]   mc_row;
    logic                    mc_open;
    logic                    mc_pend;

    genvar p, b;

    generate
        for (p = 0; p < NUM_RT; p++) begin : g_port
            mem_port_ctrl u_ctrl (
                .clk          (clk),
                .rst_n        (rst_n),
                .req          (rt_req[p]),
                .bank_sel     (port_bank[p]),
                .row          (port_row[p]),
                .bank_req     (port_req[p]),
                .gnt          (port_gnt[p]),
                .bank_rd_data (bank_rd_data),
                .rsp          (rt_rsp[p])
            );

            assign port_we[p]   = (rt_req[p].op == OP_WRITE);
            assign port_data[p] = rt_req[p].data;
            assign port_gnt[p]  = bank_core_gnt[port_bank[p]][p]; // grant from own bank.
        end
    endgenerate

    // steer each port's request line to the arbiter of its bank.
    always_comb begin
        for (int i = 0; i < `MEM_NUM_BANK; i++) begin
            for (int j = 0; j < NUM_RT; j++) begin
                bank_core_req[i][j] = port_req[j] && (port_bank[j] == `MEM_BANK_W'(i));
            end
        end
    end

    assign mc_bank = addr_mc[`MEM_BANK_LSB +: `MEM_BANK_W];
    assign mc_row  = addr_mc[`MEM_ROW_LSB +: `MEM_ROW_W];
    assign mc_open = re_mc && !mc_pend && !rdy_mc; // one access per held request.

    generate
        for (b = 0; b < `MEM_NUM_BANK; b++) begin : g_bank
            assign mc_req[b] = mc_open && (mc_bank == `MEM_BANK_W'(b));

            bank_arbiter #(.NUM_RT(NUM_RT)) u_arb (
                .clk       (clk),
                .rst_n     (rst_n),
                .core_req  (bank_core_req[b]),
                .core_we   (port_we),
                .core_row  (port_row),
                .core_data (port_data),
                .mc_req    (mc_req[b]),
                .mc_row    (mc_row),
                .clr_busy  (clr_busy[b]),
                .core_gnt  (bank_core_gnt[b]),
                .mc_gnt    (mc_gnt[b]),
                .cmd       (bank_cmd[b])
            );

            mem_bank u_bank (
                .clk      (clk),
                .rst_n    (rst_n),
                .cmd      (bank_cmd[b]),
                .rd_data  (bank_rd_data[b]),
                .clr_busy (clr_busy[b])
            );
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mc_pend <= 1'b0;
            rdy_mc  <= 1'b0;
        end else begin
            mc_pend <= |mc_gnt;
            rdy_mc  <= mc_pend;
        end
    end

    // bank choice is kept so the output stage picks the right read word.
    always_ff @(posedge clk) begin
        if (|mc_gnt) begin
            mc_bank_q <= mc_bank;
        end
        if (mc_pend) begin
            data_mc <= bank_rd_data[mc_bank_q];
        end
    end

endmodule

//--- mem_main_patterns.hex
// columns: batch port op chk address write_data expected_read_data
// port 4 is the memory controller, op 1 read and 2 write, chk 1 checks the last column
01 0 1 1 00000000 0 0
01 4 1 1 00000ff0 0 0
02 0 2 0 00000010 0123456789abcdef0011223344556677 0
03 0 1 1 00000010 0 0123456789abcdef0011223344556677
04 1 2 0 00000024 fedcba98765432108899aabbccddeeff 0
05 1 1 1 00000024 0 fedcba98765432108899aabbccddeeff
06 2 1 1 00000010 0 0123456789abcdef0011223344556677
07 3 1 1 00000024 0 fedcba98765432108899aabbccddeeff
08 4 1 1 00000010 0 0123456789abcdef0011223344556677
09 4 1 1 00000024 0 fedcba98765432108899aabbccddeeff
0a 3 2 0 00000038 a5a5a5a55a5a5a5ac3c3c3c33c3c3c3c 0
0b 4 1 1 00000038 0 a5a5a5a55a5a5a5ac3c3c3c33c3c3c3c
0c 0 1 1 00000038 0 a5a5a5a55a5a5a5ac3c3c3c33c3c3c3c
0c 1 1 1 0000003c 0 0
0d 0 2 0 00000100 d0d0d0d0 0
0d 1 2 0 00000100 d1d1d1d1 0
0d 2 2 0 00000100 d2d2d2d2 0
0d 3 2 0 00000100 d3d3d3d3 0
0e 0 1 0 00000100 0 0
0e 4 1 0 00000100 0 0
0f 0 1 0 00000100 0 0
0f 1 2 0 00000100 e1e1e1e1 0
0f 2 1 0 00000100 0 0
0f 3 2 0 00000140 e3e3e3e3 0
10 0 1 1 00000140 0 e3e3e3e3
10 1 1 1 00000140 0 e3e3e3e3
10 2 1 1 00000140 0 e3e3e3e3
10 3 1 1 00000140 0 e3e3e3e3
10 4 1 1 00000140 0 e3e3e3e3
11 0 2 0 00000200 f0f0f0f0 0
11 1 2 0 00000204 f1f1f1f1 0
11 2 1 1 00000208 0 0
11 3 1 0 00000200 0 0
11 4 1 1 00000010 0 0123456789abcdef0011223344556677
12 1 2 0 00000050 1111222233334444555566667777abcd 0
13 2 1 1 00001050 0 1111222233334444555566667777abcd
14 3 1 1 80000053 0 1111222233334444555566667777abcd
15 4 1 1 fffff053 0 1111222233334444555566667777abcd
16 0 2 0 00000054 22220001 0
17 0 2 0 00000058 33330002 0
18 0 2 0 0000005c 44440003 0
19 1 1 1 00000050 0 1111222233334444555566667777abcd
1a 2 1 1 00000055 0 22220001
1b 3 1 1 0000a05a 0 33330002
1c 4 1 1 0000005f 0 44440003
1d 0 2 0 00000060 a0 0
1d 1 2 0 00000064 a1 0
1d 2 2 0 00000068 a2 0
1d 3 2 0 0000006c a3 0
1e 0 1 1 0000006c 0 a3
1e 1 1 1 00000068 0 a2
1e 2 1 1 00000064 0 a1
1e 3 1 1 00000060 0 a0
1e 4 1 1 00000050 0 1111222233334444555566667777abcd
1f 2 2 0 00001050 ffffffffffffffffffffffffffffffff 0
20 4 1 1 00000050 0 ffffffffffffffffffffffffffffffff
20 0 1 1 00000054 0 22220001
21 3 1 1 0000005d 0 44440003
21 0 1 1 00000050 0 ffffffffffffffffffffffffffffffff

//--- mem_main_tb.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_main_tb import mem_pkg::*; ();

    localparam int NUM_RT    = `MEM_NUM_RT;
    localparam int MC_PORT   = NUM_RT; // slot of the memory controller.
    localparam int NUM_FLD   = 7;
    localparam int MAX_LINES = 64;
    localparam int CORE_MAX  = NUM_RT + 3; // launch, queue behind the others and an mc read, access.

    logic                   clk;
    logic                   rst_n;
    mem_req_t               rt_req [NUM_RT];
    mem_rsp_t               rt_rsp [NUM_RT];
    logic                   re_mc;
    logic [`MEM_ADDR_W-1:0] addr_mc;
    logic [`MEM_DATA_W-1:0] data_mc;
    logic                   rdy_mc;

    logic [`MEM_DATA_W-1:0] raw [MAX_LINES*NUM_FLD];
    logic [`MEM_DATA_W-1:0] model [`MEM_NUM_BANK][`MEM_BANK_DEPTH];

    int                     pat_batch [MAX_LINES];
    int                     pat_port [MAX_LINES];
    int                     pat_op [MAX_LINES]; // 1 read, 2 write.
    int                     pat_chk [MAX_LINES];
    logic [`MEM_ADDR_W-1:0] pat_addr [MAX_LINES];
    logic [`MEM_DATA_W-1:0] pat_data [MAX_LINES];
    logic [`MEM_DATA_W-1:0] pat_exp [MAX_LINES];

    int num_lines;
    int cyc;
    int limit;
    int slot_line [NUM_RT+1];
    int slot_gap [NUM_RT+1];
    int slot_start [NUM_RT+1];
    int slot_st [NUM_RT+1]; // 0 free, 1 gap, 2 in flight.

    mem_main #(.NUM_RT(NUM_RT)) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .rt_req  (rt_req),
        .rt_rsp  (rt_rsp),
        .re_mc   (re_mc),
        .addr_mc (addr_mc),
        .data_mc (data_mc),
        .rdy_mc  (rdy_mc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cyc = 0;
        while (limit == 0 || cyc <= limit) begin
            @(posedge clk);
            cyc = cyc + 1;
        end
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped by the cycle limit");
    end

    function automatic int bank_of(input logic [`MEM_ADDR_W-1:0] a);
        return int'(a[3:2]);
    endfunction

    function automatic int row_of(input logic [`MEM_ADDR_W-1:0] a);
        return int'(a[11:4]);
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    // a port with nothing in flight must keep its rdy low.
    task automatic check_stray_rdy();
        for (int s = 0; s < NUM_RT; s++) begin
            assert (slot_st[s] == 2 || !rt_rsp[s].rdy)
                else report_mismatch($sformatf("port %0d rdy without a request", s));
        end
        assert (slot_st[MC_PORT] == 2 || !rdy_mc)
            else report_mismatch("rdy_mc without a request");
    endtask

    task automatic mc_read(input logic [`MEM_ADDR_W-1:0] a, output logic [`MEM_DATA_W-1:0] d,
                           output int lat);
        re_mc   = 1'b1;
        addr_mc = a;
        lat     = 0;
        do begin
            @(posedge clk);
            #1;
            lat = lat + 1;
        end while (!rdy_mc);
        d     = data_mc;
        re_mc = 1'b0;
        @(posedge clk); // mc request must drop for a cycle.
        #1;
        assert (!rdy_mc) else report_mismatch("rdy_mc high for more than one cycle");
    endtask

    task automatic launch(input int s);
        int l;
        l = slot_line[s];
        slot_start[s] = cyc;
        slot_st[s]    = 2;
        if (s == MC_PORT) begin
            re_mc   = 1'b1;
            addr_mc = pat_addr[l];
        end else begin
            rt_req[s].op   = (pat_op[l] == 2) ? OP_WRITE : OP_READ;
            rt_req[s].addr = pat_addr[l];
            rt_req[s].data = pat_data[l];
        end
    endtask

    task automatic complete(input int s);
        int l;
        int lat;
        logic [`MEM_DATA_W-1:0] got;
        logic [`MEM_DATA_W-1:0] want;
        l    = slot_line[s];
        lat  = cyc - slot_start[s];
        want = model[bank_of(pat_addr[l])][row_of(pat_addr[l])];
        if (s == MC_PORT) begin
            got   = data_mc;
            re_mc = 1'b0;
            assert (lat == 2)
                else report_mismatch($sformatf("mc rdy after %0d cycles, not 2", lat));
        end else begin
            got          = rt_rsp[s].data;
            rt_req[s].op = OP_IDLE;
            assert (lat <= CORE_MAX)
                else report_mismatch($sformatf("port %0d rdy after %0d cycles", s, lat));
        end
        if (pat_op[l] == 2) begin
            model[bank_of(pat_addr[l])][row_of(pat_addr[l])] = pat_data[l];
        end else begin
            assert (got == want) else report_mismatch($sformatf(
                "line %0d port %0d addr %h read %h, expected %h", l, s, pat_addr[l], got, want));
            assert (pat_chk[l] == 0 || pat_exp[l] == want) else report_mismatch($sformatf(
                "line %0d pattern value %h differs from model %h", l, pat_exp[l], want));
        end
    endtask

    // lines of one batch run side by side after random gaps.
    // a batch aimed at a single bank shares one gap so its ports collide.
    task automatic run_batch(input int first, input int last);
        int   p;
        int   pending;
        int   gap;
        logic one_bank;
        for (int s = 0; s <= NUM_RT; s++) begin
            slot_st[s] = 0;
        end
        one_bank = 1'b1;
        for (int i = first; i <= last; i++) begin
            p = pat_port[i];
            if (p > NUM_RT || slot_st[p] != 0 || (p == MC_PORT && pat_op[i] != 1)) begin
                report_failure($sformatf("pattern line %0d has a bad port or op", i));
            end
            if (bank_of(pat_addr[i]) != bank_of(pat_addr[first])) begin
                one_bank = 1'b0;
            end
            slot_line[p] = i;
            slot_gap[p]  = int'($urandom % 4);
            slot_st[p]   = 1;
        end
        gap = int'($urandom % 4);
        if (one_bank) begin
            for (int i = first; i <= last; i++) begin
                slot_gap[pat_port[i]] = gap;
            end
        end
        pending = last - first + 1;
        while (pending > 0) begin
            for (int s = 0; s <= NUM_RT; s++) begin
                if (slot_st[s] == 1 && slot_gap[s] == 0) begin
                    launch(s);
                end else if (slot_st[s] == 1) begin
                    slot_gap[s] = slot_gap[s] - 1;
                end
            end
            @(posedge clk);
            #1;
            check_stray_rdy();
            for (int s = 0; s <= NUM_RT; s++) begin
                if (slot_st[s] == 2 && ((s == MC_PORT) ? rdy_mc : rt_rsp[s].rdy)) begin
                    complete(s);
                    slot_st[s] = 0;
                    pending    = pending - 1;
                end
            end
        end
        @(posedge clk);
        #1;
        check_stray_rdy();
    endtask

    initial begin
        int i;
        int j;
        int lat;
        logic [`MEM_DATA_W-1:0] d;
        void'($urandom(32'h63d01708));
        limit   = 0;
        rst_n   = 1'b0;
        re_mc   = 1'b0;
        addr_mc = '0;
        for (int p = 0; p < NUM_RT; p++) begin
            rt_req[p] = '{op: OP_IDLE, addr: '0, data: '0};
        end
        for (int k = 0; k < MAX_LINES * NUM_FLD; k++) begin
            raw[k] = '1; // end marker for unused lines.
        end
        $readmemh("mem_main_patterns.hex", raw);
        num_lines = 0;
        while (num_lines < MAX_LINES && raw[num_lines*NUM_FLD] != '1) begin
            pat_batch[num_lines] = int'(raw[num_lines*NUM_FLD][7:0]);
            pat_port[num_lines]  = int'(raw[num_lines*NUM_FLD+1][7:0]);
            pat_op[num_lines]    = int'(raw[num_lines*NUM_FLD+2][7:0]);
            pat_chk[num_lines]   = int'(raw[num_lines*NUM_FLD+3][7:0]);
            pat_addr[num_lines]  = raw[num_lines*NUM_FLD+4][`MEM_ADDR_W-1:0];
            pat_data[num_lines]  = raw[num_lines*NUM_FLD+5];
            pat_exp[num_lines]   = raw[num_lines*NUM_FLD+6];
            num_lines = num_lines + 1;
        end
        if (num_lines == 0) begin
            report_failure("the pattern file is missing or holds no lines");
        end
        for (int b = 0; b < `MEM_NUM_BANK; b++) begin
            for (int r = 0; r < `MEM_BANK_DEPTH; r++) begin
                model[b][r] = '0;
            end
        end
        limit = `MEM_BANK_DEPTH + 40 * num_lines + 4 * `MEM_NUM_BANK * `MEM_BANK_DEPTH + 20;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // no responses while the banks clear themselves.
        repeat (`MEM_BANK_DEPTH + 4) begin
            @(posedge clk);
            #1;
            for (int p = 0; p < NUM_RT; p++) begin
                assert (!rt_rsp[p].rdy)
                    else report_mismatch($sformatf("port %0d rdy after reset", p));
            end
            assert (!rdy_mc) else report_mismatch("rdy_mc high after reset");
        end

        for (int b = 0; b < `MEM_NUM_BANK; b++) begin
            for (int r = 0; r < `MEM_BANK_DEPTH; r++) begin
                mc_read({20'd0, r[7:0], b[1:0], 2'b00}, d, lat);
                assert (d == '0 && lat == 2) else report_mismatch($sformatf(
                    "bank %0d row %0d read %h after %0d cycles", b, r, d, lat));
            end
        end

        i = 0;
        while (i < num_lines) begin
            j = i;
            while (j + 1 < num_lines && pat_batch[j+1] == pat_batch[i]) begin
                j = j + 1;
            end
            run_batch(i, j);
            i = j + 1;
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

    // request opcode from a core port.
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_e;

    // port controller states.
    typedef enum logic [1:0] {
        PORT_IDLE = 2'd0,
        PORT_WAIT = 2'd1, // waiting for a bank grant.
        PORT_BUSY = 2'd2  // bank access in flight.
    } port_state_e;

    typedef struct packed {
        mem_op_e                op;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic                   rdy;
        logic [`MEM_DATA_W-1:0] data;
    } mem_rsp_t;

    // one access to a single bank.
    typedef struct packed {
        logic                   en;
        logic                   we;
        logic [`MEM_ROW_W-1:0]  row;
        logic [`MEM_DATA_W-1:0] data;
    } bank_cmd_t;

endpackage

//--- mem_port_ctrl.sv
`timescale 1ns/1ps
`include "mem_defines.svh"

module mem_port_ctrl import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_req_t               req,
    output logic [`MEM_BANK_W-1:0] bank_sel,
    output logic [`MEM_ROW_W-1:0]  row,
    output logic                   bank_req,
    input  logic                   gnt,
    input  logic [`MEM_DATA_W-1:0] bank_rd_data [`MEM_NUM_BANK],
    output mem_rsp_t               rsp
);

    port_state_e            state;
    port_state_e            state_nxt;
    logic [`MEM_BANK_W-1:0] bank_q;
    logic                   rdy_q;
    logic [`MEM_DATA_W-1:0] data_q;

    // bits above the row and the byte offset are ignored.
    assign bank_sel = req.addr[`MEM_BANK_LSB +: `MEM_BANK_W];
    assign row      = req.addr[`MEM_ROW_LSB +: `MEM_ROW_W];
    assign bank_req = (state == PORT_WAIT);

    always_comb begin
        state_nxt = state;
        case (state)
            PORT_IDLE: begin
                // the old request is still held during the rdy pulse.
                if (req.op != OP_IDLE && !rdy_q) begin
                    state_nxt = PORT_WAIT;
                end
            end
            PORT_WAIT: begin
                if (gnt) begin
                    state_nxt = PORT_BUSY;
                end
            end
            PORT_BUSY: state_nxt = PORT_IDLE;
            default:   state_nxt = PORT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PORT_IDLE;
            rdy_q <= 1'b0;
        end else begin
            state <= state_nxt;
            rdy_q <= (state == PORT_BUSY); // one-cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (state == PORT_WAIT && gnt) begin
            bank_q <= bank_sel;
        end
        if (state == PORT_BUSY && req.op == OP_READ) begin
            data_q <= bank_rd_data[bank_q]; // bank word is valid the cycle after grant.
        end
    end

    assign rsp = '{rdy: rdy_q, data: data_q};

endmodule

//--- run.sh
#!/usr/bin/env bash
# compile and run the shared memory testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f all.f \
    --top-module mem_main_tb \
    -o mem_main_sim

# the simulator exits non-zero on a failed check, the log decides the result.
./obj_dir/mem_main_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    exit 0
else
    exit 1
fi
